// File: source/bp_dma_pkg.sv
/* One DMA packet always moves one 64-byte cache block.
   The AXI beat width is not fixed here and comes from data_width_p. */
package bp_dma_pkg;

  localparam int dma_addr_width     = 32;
  localparam int block_bytes        = 64;
  localparam int block_offset_width = $clog2(block_bytes);
  localparam int fill_width         = block_bytes * 8;

  // AXI4 burst and cache encodings
  localparam logic [1:0] axi_burst_wrap    = 2'b10;
  // Normal non-cacheable bufferable
  localparam logic [3:0] axi_cache_default = 4'b0011;

  // Byte address, seen flat or as block number plus offset in block
  typedef union packed {
    logic [dma_addr_width-1:0] flat;
    struct packed {
      logic [dma_addr_width-block_offset_width-1:0] block;
      logic [block_offset_width-1:0]                offset;
    } blk;
  } dma_addr_u;

endpackage

// File: source/dma_pkt_decode.sv
/* Holds one decoded command, so one packet can wait while a burst runs.
   A write always starts at the block base. A read starts at the beat that was asked for. */
module dma_pkt_decode
  #(parameter int data_width_p = 128
    , localparam int beats_lp = bp_dma_pkg::fill_width / data_width_p
    , localparam int beat_idx_width_lp = $clog2(beats_lp)
    )
  (input                                           clk_i
   , input                                         arst_n_i

   , input                                         dma_pkt_v_i
   , input                                         dma_pkt_write_i
   , input bp_dma_pkg::dma_addr_u                  dma_pkt_addr_i
   , output logic                                  dma_pkt_ready_o

   , output logic                                  cmd_v_o
   , output logic                                  cmd_write_o
   , output logic [bp_dma_pkg::dma_addr_width-1:0] cmd_addr_o
   , output logic [beat_idx_width_lp-1:0]          cmd_beat_o
   , input                                         cmd_ready_i
   );

  import bp_dma_pkg::*;

  localparam int beat_shift_lp = $clog2(data_width_p / 8);

  logic pkt_fire;

  // Slot frees up in the same cycle the engine takes the command
  assign dma_pkt_ready_o = ~cmd_v_o | cmd_ready_i;
  assign pkt_fire        = dma_pkt_v_i & dma_pkt_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmd_v_o <= 1'b0;
    end else if (dma_pkt_ready_o) begin
      cmd_v_o <= dma_pkt_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pkt_fire) begin
      cmd_write_o <= dma_pkt_write_i;
      if (dma_pkt_write_i) begin
        cmd_addr_o <= {dma_pkt_addr_i.blk.block, block_offset_width'(0)};
        cmd_beat_o <= '0;
      end else begin
        // Critical beat first, memory wraps the rest of the block
        cmd_addr_o <= {dma_pkt_addr_i.flat[dma_addr_width-1:beat_shift_lp],
                       beat_shift_lp'(0)};
        cmd_beat_o <= dma_pkt_addr_i.blk.offset[block_offset_width-1:beat_shift_lp];
      end
    end
  end

endmodule

// File: source/fill_to_beats.sv
/* Beats leave in block order starting at beat 0.
   No new fill is taken until the last beat of the current one is gone. */
module fill_to_beats
  #(parameter int data_width_p = 128
    , localparam int beats_lp = bp_dma_pkg::fill_width / data_width_p
    , localparam int beat_idx_width_lp = $clog2(beats_lp)
    )
  (input                                       clk_i
   , input                                     arst_n_i

   , input [bp_dma_pkg::fill_width-1:0]        fill_i
   , input                                     fill_v_i
   , output logic                              fill_ready_o

   , output logic [data_width_p-1:0]           beat_data_o
   , output logic                              beat_v_o
   , input                                     beat_ready_i
   );

  import bp_dma_pkg::*;

  logic [fill_width-1:0]        fill_q;
  logic [beat_idx_width_lp-1:0] cnt_q;
  logic                         busy_q;
  logic                         fill_fire;
  logic                         beat_fire;

  assign fill_ready_o = ~busy_q;
  assign fill_fire    = fill_v_i & fill_ready_o;
  assign beat_v_o     = busy_q;
  assign beat_data_o  = fill_q[data_width_p-1:0];
  assign beat_fire    = beat_v_o & beat_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (fill_fire) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (beat_fire) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == beat_idx_width_lp'(beats_lp - 1)) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Next beat always sits in the low slice
  always_ff @(posedge clk_i) begin
    if (fill_fire) begin
      fill_q <= fill_i;
    end else if (beat_fire) begin
      fill_q <= fill_q >> data_width_p;
    end
  end

endmodule

// File: source/beats_to_fill.sv
/* Beats must arrive in wrap order from rbeat_first_idx_i, one burst per fill.
   A finished fill blocks further beats until the consumer takes it. */
module beats_to_fill
  #(parameter int data_width_p = 128
    , localparam int beats_lp = bp_dma_pkg::fill_width / data_width_p
    , localparam int beat_idx_width_lp = $clog2(beats_lp)
    )
  (input                                       clk_i
   , input                                     arst_n_i

   , input [data_width_p-1:0]                  rbeat_data_i
   , input                                     rbeat_v_i
   , input                                     rbeat_last_i
   , input [beat_idx_width_lp-1:0]             rbeat_first_idx_i
   , output logic                              rbeat_ready_o

   , output logic [bp_dma_pkg::fill_width-1:0] fill_o
   , output logic                              fill_v_o
   , input                                     fill_ready_i
   );

  logic [beat_idx_width_lp-1:0] cnt_q;
  logic [beat_idx_width_lp-1:0] slot;
  logic                         rbeat_fire;

  assign rbeat_ready_o = ~fill_v_o;
  assign rbeat_fire    = rbeat_v_i & rbeat_ready_o;
  // Index width equals log2 of beats, so the sum wraps at block end
  assign slot          = rbeat_first_idx_i + cnt_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q    <= '0;
      fill_v_o <= 1'b0;
    end else begin
      if (rbeat_fire) begin
        cnt_q <= rbeat_last_i ? '0 : cnt_q + 1'b1;
      end
      if (rbeat_fire && rbeat_last_i) begin
        fill_v_o <= 1'b1;
      end else if (fill_ready_i) begin
        fill_v_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rbeat_fire) begin
      fill_o[slot*data_width_p +: data_width_p] <= rbeat_data_i;
    end
  end

endmodule

// File: source/axi_burst_engine.sv
/* One wrap burst of a full block at a time; no IDs, and BRESP/RRESP are ignored.
   The command address must already be aligned to the beat size. */
module axi_burst_engine
  #(parameter int data_width_p = 128
    , localparam int beats_lp = bp_dma_pkg::fill_width / data_width_p
    , localparam int beat_idx_width_lp = $clog2(beats_lp)
    , localparam int strb_width_lp = data_width_p / 8
    )
  (input                                           clk_i
   , input                                         arst_n_i

   , input                                         cmd_v_i
   , input                                         cmd_write_i
   , input [bp_dma_pkg::dma_addr_width-1:0]        cmd_addr_i
   , input [beat_idx_width_lp-1:0]                 cmd_beat_i
   , output logic                                  cmd_ready_o

   , input [data_width_p-1:0]                      beat_data_i
   , input                                         beat_v_i
   , output logic                                  beat_ready_o

   , output logic [data_width_p-1:0]               rbeat_data_o
   , output logic                                  rbeat_v_o
   , output logic                                  rbeat_last_o
   , output logic [beat_idx_width_lp-1:0]          rbeat_first_idx_o
   , input                                         rbeat_ready_i

   , output logic [bp_dma_pkg::dma_addr_width-1:0] m_axi_awaddr_o
   , output logic [7:0]                            m_axi_awlen_o
   , output logic [2:0]                            m_axi_awsize_o
   , output logic [1:0]                            m_axi_awburst_o
   , output logic [3:0]                            m_axi_awcache_o
   , output logic                                  m_axi_awvalid_o
   , input                                         m_axi_awready_i

   , output logic [data_width_p-1:0]               m_axi_wdata_o
   , output logic [strb_width_lp-1:0]              m_axi_wstrb_o
   , output logic                                  m_axi_wlast_o
   , output logic                                  m_axi_wvalid_o
   , input                                         m_axi_wready_i

   , input                                         m_axi_bvalid_i
   , output logic                                  m_axi_bready_o

   , output logic [bp_dma_pkg::dma_addr_width-1:0] m_axi_araddr_o
   , output logic [7:0]                            m_axi_arlen_o
   , output logic [2:0]                            m_axi_arsize_o
   , output logic [1:0]                            m_axi_arburst_o
   , output logic [3:0]                            m_axi_arcache_o
   , output logic                                  m_axi_arvalid_o
   , input                                         m_axi_arready_i

   , input [data_width_p-1:0]                      m_axi_rdata_i
   , input                                         m_axi_rlast_i
   , input                                         m_axi_rvalid_i
   , output logic                                  m_axi_rready_o
   );

  import bp_dma_pkg::*;

  localparam logic [2:0] s_idle  = 3'd0;
  localparam logic [2:0] s_addr  = 3'd1;
  localparam logic [2:0] s_wdata = 3'd2;
  localparam logic [2:0] s_wresp = 3'd3;
  localparam logic [2:0] s_rdata = 3'd4;

  localparam logic [7:0] len_lp  = 8'(beats_lp - 1);
  localparam logic [2:0] size_lp = 3'($clog2(strb_width_lp));

  logic [2:0]                   state_q;
  logic [2:0]                   state_d;
  logic                         write_q;
  logic [dma_addr_width-1:0]    addr_q;
  logic [beat_idx_width_lp-1:0] beat_q;
  logic [beat_idx_width_lp-1:0] wcnt_q;
  logic                         cmd_fire;
  logic                         w_fire;
  logic                         r_fire;

  assign cmd_ready_o = (state_q == s_idle);
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  // Address channels
  assign m_axi_awaddr_o  = addr_q;
  assign m_axi_awlen_o   = len_lp;
  assign m_axi_awsize_o  = size_lp;
  assign m_axi_awburst_o = axi_burst_wrap;
  assign m_axi_awcache_o = axi_cache_default;
  assign m_axi_awvalid_o = (state_q == s_addr) & write_q;
  assign m_axi_araddr_o  = addr_q;
  assign m_axi_arlen_o   = len_lp;
  assign m_axi_arsize_o  = size_lp;
  assign m_axi_arburst_o = axi_burst_wrap;
  assign m_axi_arcache_o = axi_cache_default;
  assign m_axi_arvalid_o = (state_q == s_addr) & ~write_q;

  // Write data and response
  assign m_axi_wdata_o  = beat_data_i;
  assign m_axi_wstrb_o  = '1;
  assign m_axi_wlast_o  = (wcnt_q == beat_idx_width_lp'(beats_lp - 1));
  assign m_axi_wvalid_o = (state_q == s_wdata) & beat_v_i;
  assign beat_ready_o   = (state_q == s_wdata) & m_axi_wready_i;
  assign w_fire         = m_axi_wvalid_o & m_axi_wready_i;
  assign m_axi_bready_o = (state_q == s_wresp);

  // Read data goes straight to the fill assembler
  assign rbeat_data_o      = m_axi_rdata_i;
  assign rbeat_last_o      = m_axi_rlast_i;
  assign rbeat_first_idx_o = beat_q;
  assign rbeat_v_o         = (state_q == s_rdata) & m_axi_rvalid_i;
  assign m_axi_rready_o    = (state_q == s_rdata) & rbeat_ready_i;
  assign r_fire            = m_axi_rvalid_i & m_axi_rready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      s_idle: begin
        if (cmd_v_i) state_d = s_addr;
      end
      s_addr: begin
        if (m_axi_awvalid_o && m_axi_awready_i) state_d = s_wdata;
        else if (m_axi_arvalid_o && m_axi_arready_i) state_d = s_rdata;
      end
      s_wdata: begin
        if (w_fire && m_axi_wlast_o) state_d = s_wresp;
      end
      s_wresp: begin
        if (m_axi_bvalid_i) state_d = s_idle;
      end
      s_rdata: begin
        if (r_fire && m_axi_rlast_i) state_d = s_idle;
      end
      default: state_d = s_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= s_idle;
      wcnt_q  <= '0;
    end else begin
      state_q <= state_d;
      if (cmd_fire) begin
        wcnt_q <= '0;
      end else if (w_fire) begin
        wcnt_q <= wcnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      write_q <= cmd_write_i;
      addr_q  <= cmd_addr_i;
      beat_q  <= cmd_beat_i;
    end
  end

endmodule

// File: source/bp_dma_axi_top.sv
/* Single clock, one AXI burst in flight, AXI IDs and responses unused.
   data_width_p may be 64, 128 or 256. */
module bp_dma_axi_top
  #(parameter int data_width_p = 128
    , localparam int strb_width_lp = data_width_p / 8
    )
  (input                                           clk_i
   , input                                         arst_n_i

   , input                                         dma_pkt_v_i
   , input                                         dma_pkt_write_i
   , input bp_dma_pkg::dma_addr_u                  dma_pkt_addr_i
   , output logic                                  dma_pkt_ready_o

   , input [bp_dma_pkg::fill_width-1:0]            dma_data_i
   , input                                         dma_data_v_i
   , output logic                                  dma_data_ready_o

   , output logic [bp_dma_pkg::fill_width-1:0]     dma_data_o
   , output logic                                  dma_data_v_o
   , input                                         dma_data_ready_i

   , output logic [bp_dma_pkg::dma_addr_width-1:0] m_axi_awaddr_o
   , output logic [7:0]                            m_axi_awlen_o
   , output logic [2:0]                            m_axi_awsize_o
   , output logic [1:0]                            m_axi_awburst_o
   , output logic [3:0]                            m_axi_awcache_o
   , output logic                                  m_axi_awvalid_o
   , input                                         m_axi_awready_i

   , output logic [data_width_p-1:0]               m_axi_wdata_o
   , output logic [strb_width_lp-1:0]              m_axi_wstrb_o
   , output logic                                  m_axi_wlast_o
   , output logic                                  m_axi_wvalid_o
   , input                                         m_axi_wready_i

   , input                                         m_axi_bvalid_i
   , output logic                                  m_axi_bready_o

   , output logic [bp_dma_pkg::dma_addr_width-1:0] m_axi_araddr_o
   , output logic [7:0]                            m_axi_arlen_o
   , output logic [2:0]                            m_axi_arsize_o
   , output logic [1:0]                            m_axi_arburst_o
   , output logic [3:0]                            m_axi_arcache_o
   , output logic                                  m_axi_arvalid_o
   , input                                         m_axi_arready_i

   , input [data_width_p-1:0]                      m_axi_rdata_i
   , input                                         m_axi_rlast_i
   , input                                         m_axi_rvalid_i
   , output logic                                  m_axi_rready_o
   );

  import bp_dma_pkg::*;

  localparam int beat_idx_width_lp = $clog2(fill_width / data_width_p);

  logic                         cmd_v;
  logic                         cmd_write;
  logic [dma_addr_width-1:0]    cmd_addr;
  logic [beat_idx_width_lp-1:0] cmd_beat;
  logic                         cmd_ready;
  logic [data_width_p-1:0]      beat_data;
  logic                         beat_v;
  logic                         beat_ready;
  logic [data_width_p-1:0]      rbeat_data;
  logic                         rbeat_v;
  logic                         rbeat_last;
  logic [beat_idx_width_lp-1:0] rbeat_first_idx;
  logic                         rbeat_ready;

  dma_pkt_decode
   #(.data_width_p(data_width_p))
   u_decode
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.dma_pkt_v_i(dma_pkt_v_i)
     ,.dma_pkt_write_i(dma_pkt_write_i)
     ,.dma_pkt_addr_i(dma_pkt_addr_i)
     ,.dma_pkt_ready_o(dma_pkt_ready_o)
     ,.cmd_v_o(cmd_v)
     ,.cmd_write_o(cmd_write)
     ,.cmd_addr_o(cmd_addr)
     ,.cmd_beat_o(cmd_beat)
     ,.cmd_ready_i(cmd_ready)
     );

  fill_to_beats
   #(.data_width_p(data_width_p))
   u_fill_to_beats
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.fill_i(dma_data_i)
     ,.fill_v_i(dma_data_v_i)
     ,.fill_ready_o(dma_data_ready_o)
     ,.beat_data_o(beat_data)
     ,.beat_v_o(beat_v)
     ,.beat_ready_i(beat_ready)
     );

  beats_to_fill
   #(.data_width_p(data_width_p))
   u_beats_to_fill
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.rbeat_data_i(rbeat_data)
     ,.rbeat_v_i(rbeat_v)
     ,.rbeat_last_i(rbeat_last)
     ,.rbeat_first_idx_i(rbeat_first_idx)
     ,.rbeat_ready_o(rbeat_ready)
     ,.fill_o(dma_data_o)
     ,.fill_v_o(dma_data_v_o)
     ,.fill_ready_i(dma_data_ready_i)
     );

  axi_burst_engine
   #(.data_width_p(data_width_p))
   u_engine
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.cmd_v_i(cmd_v)
     ,.cmd_write_i(cmd_write)
     ,.cmd_addr_i(cmd_addr)
     ,.cmd_beat_i(cmd_beat)
     ,.cmd_ready_o(cmd_ready)
     ,.beat_data_i(beat_data)
     ,.beat_v_i(beat_v)
     ,.beat_ready_o(beat_ready)
     ,.rbeat_data_o(rbeat_data)
     ,.rbeat_v_o(rbeat_v)
     ,.rbeat_last_o(rbeat_last)
     ,.rbeat_first_idx_o(rbeat_first_idx)
     ,.rbeat_ready_i(rbeat_ready)
     ,.*
     );

endmodule

// File: tb/axi_mem_model.sv
/* AXI slave for one burst at a time per direction; wrap bursts of a whole block only.
   Ready and RVALID stall at stall_pct_i percent; unwritten memory reads an address pattern. */
module axi_mem_model
  #(parameter int data_width_p = 128)
  (input                           clk_i
   , input                         arst_n_i
   , input [6:0]                   stall_pct_i

   , input [31:0]                  awaddr_i
   , input                         awvalid_i
   , output logic                  awready_o
   , input [data_width_p-1:0]      wdata_i
   , input                         wlast_i
   , input                         wvalid_i
   , output logic                  wready_o
   , output logic                  bvalid_o
   , input                         bready_i

   , input [31:0]                  araddr_i
   , input                         arvalid_i
   , output logic                  arready_o
   , output logic [data_width_p-1:0] rdata_o
   , output logic                  rlast_o
   , output logic                  rvalid_o
   , input                         rready_i
   );
  timeunit 1ns;
  timeprecision 100ps;

  localparam int beats_lp = 512 / data_width_p;
  localparam int shift_lp = $clog2(data_width_p / 8);

  logic [data_width_p-1:0] mem [int unsigned];
  logic [31:0] wr_addr;
  logic [31:0] rd_addr;
  int          wr_cnt;
  int          rd_cnt;
  logic        wr_active;
  logic        b_pend;
  logic        rd_active;
  logic        r_fired;

  // Beat address inside the block, wrapping at the block end
  function automatic int unsigned wrap_idx(input logic [31:0] addr, input int cnt);
    int unsigned first;
    begin
      first = (addr >> shift_lp) % beats_lp;
      wrap_idx = ((addr >> 6) * beats_lp) + ((first + cnt) % beats_lp);
    end
  endfunction

  function automatic logic [data_width_p-1:0] fill_pattern(input int unsigned widx);
    begin
      fill_pattern = {(data_width_p / 32){widx ^ 32'ha5c3_0f00}};
    end
  endfunction

  function automatic logic go();
    begin
      go = ($urandom % 100) >= stall_pct_i;
    end
  endfunction

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_active = 0;
      b_pend    = 0;
      rd_active = 0;
      r_fired   = 0;
      wr_cnt    = 0;
      rd_cnt    = 0;
    end else begin
      if (awvalid_i && awready_o) begin
        wr_addr   = awaddr_i;
        wr_active = 1;
        wr_cnt    = 0;
      end
      if (wvalid_i && wready_o) begin
        mem[wrap_idx(wr_addr, wr_cnt)] = wdata_i;
        wr_cnt++;
        if (wlast_i) b_pend = 1;
      end
      if (bvalid_o && bready_i) begin
        b_pend    = 0;
        wr_active = 0;
      end
      if (arvalid_i && arready_o) begin
        rd_addr   = araddr_i;
        rd_active = 1;
        rd_cnt    = 0;
      end
      if (rvalid_o && rready_i) begin
        r_fired = 1;
        rd_cnt++;
        if (rlast_o) rd_active = 0;
      end
    end
  end

  // Outputs change on the falling edge only
  always @(negedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      awready_o = 0;
      wready_o  = 0;
      bvalid_o  = 0;
      arready_o = 0;
      rvalid_o  = 0;
      rlast_o   = 0;
      rdata_o   = '0;
    end else begin
      awready_o = !wr_active && !b_pend && go();
      wready_o  = wr_active && !b_pend && go();
      bvalid_o  = b_pend;
      arready_o = !rd_active && go();
      if (!(rvalid_o && !r_fired)) begin
        rvalid_o = rd_active && go();
      end
      r_fired = 0;
      rlast_o = (rd_cnt == beats_lp - 1);
      if (mem.exists(wrap_idx(rd_addr, rd_cnt))) begin
        rdata_o = mem[wrap_idx(rd_addr, rd_cnt)];
      end else begin
        rdata_o = fill_pattern(wrap_idx(rd_addr, rd_cnt));
      end
    end
  end

endmodule

// File: tb/tb_bp_dma_axi_top.sv
/* Writes random blocks, reads them back from unaligned addresses, 128-bit AXI beats.
   The memory model and the read consumer stall at random. */
module tb_bp_dma_axi_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int dw = 128;
  localparam int n_pairs = 20;
  localparam int max_cycles = 40 * 60;

  logic clk_i = 0;
  logic arst_n_i;
  logic dma_pkt_v_i, dma_pkt_write_i, dma_pkt_ready_o;
  bp_dma_pkg::dma_addr_u dma_pkt_addr_i;
  logic [511:0] dma_data_i, dma_data_o;
  logic dma_data_v_i, dma_data_ready_o, dma_data_v_o, dma_data_ready_i;
  logic [31:0] m_axi_awaddr_o, m_axi_araddr_o;
  logic [7:0] m_axi_awlen_o, m_axi_arlen_o;
  logic [2:0] m_axi_awsize_o, m_axi_arsize_o;
  logic [1:0] m_axi_awburst_o, m_axi_arburst_o;
  logic [3:0] m_axi_awcache_o, m_axi_arcache_o;
  logic m_axi_awvalid_o, m_axi_awready_i, m_axi_wlast_o, m_axi_wvalid_o, m_axi_wready_i;
  logic m_axi_bvalid_i, m_axi_bready_o, m_axi_arvalid_o, m_axi_arready_i;
  logic m_axi_rlast_i, m_axi_rvalid_i, m_axi_rready_o;
  logic [dw-1:0] m_axi_wdata_o, m_axi_rdata_i;
  logic [dw/8-1:0] m_axi_wstrb_o;
  logic [6:0] stall_pct;

  int errors = 0;
  int cycles = 0;
  int post_rst = 0;
  int wbeat = 0;
  int writes_done = 0;
  int reads_done = 0;
  logic [31:0] aw_exp_q[$];
  logic [511:0] wfill_exp_q[$];
  logic [31:0] ar_exp_q[$];
  logic [511:0] rfill_exp_q[$];
  logic [511:0] ref_mem [8];

  bp_dma_axi_top #(.data_width_p(dw)) u_bp_dma_axi_top (.*);

  axi_mem_model #(.data_width_p(dw)) u_mem
    (.clk_i(clk_i), .arst_n_i(arst_n_i), .stall_pct_i(stall_pct)
     , .awaddr_i(m_axi_awaddr_o), .awvalid_i(m_axi_awvalid_o), .awready_o(m_axi_awready_i)
     , .wdata_i(m_axi_wdata_o), .wlast_i(m_axi_wlast_o), .wvalid_i(m_axi_wvalid_o)
     , .wready_o(m_axi_wready_i), .bvalid_o(m_axi_bvalid_i), .bready_i(m_axi_bready_o)
     , .araddr_i(m_axi_araddr_o), .arvalid_i(m_axi_arvalid_o), .arready_o(m_axi_arready_i)
     , .rdata_o(m_axi_rdata_i), .rlast_o(m_axi_rlast_i), .rvalid_o(m_axi_rvalid_i)
     , .rready_i(m_axi_rready_o));

  always #2 clk_i = ~clk_i;

  // Protocol rules on the AXI and fill outputs, 16-byte beats give AXI size 4
  a_aw_fmt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_axi_awvalid_o |-> m_axi_awaddr_o[5:0] == 0 && m_axi_awlen_o == 8'd3
                        && m_axi_awsize_o == 3'd4 && m_axi_awburst_o == 2'b10
                        && m_axi_awcache_o == bp_dma_pkg::axi_cache_default)
    else begin
      errors++;
      $display("error %0t awaddr,len,size,burst,cache got %h %0d %0d %b %b exp 00 3 4 10 %b",
               $time, m_axi_awaddr_o[5:0], m_axi_awlen_o, m_axi_awsize_o, m_axi_awburst_o,
               m_axi_awcache_o, bp_dma_pkg::axi_cache_default);
    end
  a_ar_fmt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_axi_arvalid_o |-> m_axi_araddr_o[3:0] == 0 && m_axi_arlen_o == 8'd3
                        && m_axi_arsize_o == 3'd4 && m_axi_arburst_o == 2'b10
                        && m_axi_arcache_o == bp_dma_pkg::axi_cache_default)
    else begin
      errors++;
      $display("error %0t araddr,len,size,burst,cache got %h %0d %0d %b %b exp 0 3 4 10 %b",
               $time, m_axi_araddr_o[3:0], m_axi_arlen_o, m_axi_arsize_o, m_axi_arburst_o,
               m_axi_arcache_o, bp_dma_pkg::axi_cache_default);
    end
  a_wstrb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_axi_wvalid_o |-> m_axi_wstrb_o == '1)
    else begin
      errors++;
      $display("error %0t m_axi_wstrb_o got %h exp all ones", $time, m_axi_wstrb_o);
    end
  a_aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_axi_awvalid_o && !m_axi_awready_i |=> m_axi_awvalid_o && $stable(m_axi_awaddr_o))
    else begin
      errors++;
      $display("AW valid or address dropped before accept at %0t", $time);
    end
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o))
    else begin
      errors++;
      $display("AR valid or address dropped before accept at %0t", $time);
    end
  a_w_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_axi_wvalid_o && !m_axi_wready_i |=> m_axi_wvalid_o && $stable(m_axi_wdata_o))
    else begin
      errors++;
      $display("W valid or data dropped before accept at %0t", $time);
    end
  a_fill_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dma_data_v_o && !dma_data_ready_i |=> dma_data_v_o && $stable(dma_data_o))
    else begin
      errors++;
      $display("read fill dropped before accept at %0t", $time);
    end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, errors=%0d writes=%0d reads=%0d", cycles, errors,
               writes_done, reads_done);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Channel monitor and reset check
  always @(posedge clk_i) begin
    if (arst_n_i && post_rst < 3) begin
      post_rst++;
      assert (!(m_axi_awvalid_o | m_axi_wvalid_o | m_axi_arvalid_o | dma_data_v_o
                | m_axi_bready_o | m_axi_rready_o) && dma_pkt_ready_o)
        else begin
          errors++;
          $display("valid or ready wrong right after reset at %0t", $time);
        end
    end
    if (m_axi_awvalid_o && m_axi_awready_i) begin
      assert (m_axi_awaddr_o == aw_exp_q[0])
        else begin
          errors++;
          $display("error %0t m_axi_awaddr_o got %h exp %h", $time, m_axi_awaddr_o, aw_exp_q[0]);
        end
      void'(aw_exp_q.pop_front());
    end
    if (m_axi_wvalid_o && m_axi_wready_i) begin
      assert (m_axi_wdata_o == wfill_exp_q[0][wbeat*dw +: dw])
        else begin
          errors++;
          $display("error %0t m_axi_wdata_o got %h exp %h", $time, m_axi_wdata_o,
                   wfill_exp_q[0][wbeat*dw +: dw]);
        end
      assert (m_axi_wlast_o == (wbeat == 3))
        else begin
          errors++;
          $display("error %0t m_axi_wlast_o got %b exp %b", $time, m_axi_wlast_o, wbeat == 3);
        end
      wbeat++;
    end
    if (m_axi_bvalid_i && m_axi_bready_o) begin
      assert (wbeat == 4)
        else begin
          errors++;
          $display("error %0t W beat count got %0d exp 4", $time, wbeat);
        end
      wbeat = 0;
      void'(wfill_exp_q.pop_front());
      writes_done++;
    end
    if (m_axi_arvalid_o && m_axi_arready_i) begin
      assert (m_axi_araddr_o == ar_exp_q[0])
        else begin
          errors++;
          $display("error %0t m_axi_araddr_o got %h exp %h", $time, m_axi_araddr_o, ar_exp_q[0]);
        end
      void'(ar_exp_q.pop_front());
    end
  end

  // Read consumer with random back-pressure
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      dma_data_ready_i = ($urandom % 100) >= stall_pct;
      if (dma_data_v_o && dma_data_ready_i) begin
        assert (dma_data_o == rfill_exp_q[0])
          else begin
            errors++;
            $display("error %0t dma_data_o got %h exp %h", $time, dma_data_o, rfill_exp_q[0]);
          end
        void'(rfill_exp_q.pop_front());
        reads_done++;
      end
    end
  end

  task automatic send_pkt(input logic write, input logic [31:0] addr);
    logic fired;
    begin
      dma_pkt_v_i = 1;
      dma_pkt_write_i = write;
      dma_pkt_addr_i.flat = addr;
      fired = 0;
      while (!fired) begin
        fired = dma_pkt_ready_o;
        @(negedge clk_i);
      end
      dma_pkt_v_i = 0;
    end
  endtask

  task automatic drive_fill(input logic [511:0] fill);
    logic fired;
    begin
      dma_data_v_i = 1;
      dma_data_i = fill;
      fired = 0;
      while (!fired) begin
        fired = dma_data_ready_o;
        @(negedge clk_i);
      end
      dma_data_v_i = 0;
    end
  endtask

  initial begin
    logic [511:0] fill;
    logic [31:0] base;
    int blk;
    void'($urandom(32'h9b1d));
    arst_n_i = 0;
    dma_pkt_v_i = 0;
    dma_pkt_write_i = 0;
    dma_pkt_addr_i = '0;
    dma_data_i = '0;
    dma_data_v_i = 0;
    dma_data_ready_i = 0;
    stall_pct = 0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1;
    // Quiet cycles so the reset check sees no traffic
    repeat (3) @(negedge clk_i);
    for (int i = 0; i < n_pairs; i++) begin
      stall_pct = 7'($urandom % 50);
      blk = $urandom % 8;
      base = 32'h0000_4000 + blk * 64;
      for (int w = 0; w < 16; w++) fill[w*32 +: 32] = $urandom;
      ref_mem[blk] = fill;
      aw_exp_q.push_back(base);
      wfill_exp_q.push_back(fill);
      fork
        send_pkt(1'b1, base + ($urandom % 64));
        drive_fill(fill);
      join
      base = base + ($urandom % 64);
      ar_exp_q.push_back({base[31:4], 4'h0});
      rfill_exp_q.push_back(ref_mem[blk]);
      send_pkt(1'b0, base);
    end
    wait (writes_done == n_pairs && reads_done == n_pairs);
    repeat (4) @(negedge clk_i);
    $display("errors=%0d writes=%0d reads=%0d cycles=%0d", errors, writes_done, reads_done,
             cycles);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: bp_dma_axi_top.f
source/bp_dma_pkg.sv
source/dma_pkt_decode.sv
source/fill_to_beats.sv
source/beats_to_fill.sv
source/axi_burst_engine.sv
source/bp_dma_axi_top.sv
tb/axi_mem_model.sv
tb/tb_bp_dma_axi_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal \
  --top-module tb_bp_dma_axi_top \
  -f bp_dma_axi_top.f

./obj_dir/Vtb_bp_dma_axi_top > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
exit 0
